// ==== hdl/bu_pkg.sv ====
package bu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and PC width
  localparam int XLEN = 32;
  // Instruction width, no compressed forms
  localparam int ILEN = 32;
  // Exception vector width
  localparam int EXC_SIZE = 16;
  // Bit for instruction address misaligned
  localparam int CAUSE_MISALIGNED_INSTR = 0;

  // First fetch address
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // Gshare sizing
  localparam int GHIST_BITS = 4;
  localparam int BHT_BITS = 6;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // FENCE.I, matched on the whole word
  localparam logic [ILEN-1:0] FENCE_I = 32'h0000_100f;

  // func3 of the conditional branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  // JALR has a single legal func3
  localparam logic [2:0] F3_JALR = 3'b000;

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD    = 5'b00000,
    OPC_MISCMEM = 5'b00011,
    OPC_OPIMM   = 5'b00100,
    OPC_AUIPC   = 5'b00101,
    OPC_STORE   = 5'b01000,
    OPC_OP      = 5'b01100,
    OPC_LUI     = 5'b01101,
    OPC_BRANCH  = 5'b11000,
    OPC_JALR    = 5'b11001,
    OPC_JAL     = 5'b11011,
    OPC_SYSTEM  = 5'b11100
  } opc_e;

  // Resolved control-transfer operation
  typedef enum logic [3:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_FENCEI
  } br_op_e;

endpackage

// ==== hdl/bp_train_if.sv ====
// Training record, redirect stage to predictor
interface bp_train_if import bu_pkg::*; ();

  // Single-cycle strobe, one per resolved conditional branch
  logic            update;
  // PC of the branch being trained
  logic [XLEN-1:0] pc;
  // Resolved direction
  logic            taken;
  // Direction the predictor gave at lookup
  logic            predicted;

  // Producer side
  modport redirect (
    output update,
    output pc,
    output taken,
    output predicted
  );

  // Consumer side, always accepts
  modport predictor (
    input update,
    input pc,
    input taken,
    input predicted
  );

endinterface

// ==== hdl/resolve_if.sv ====
// Resolver outcome for the instruction in ID
interface resolve_if import bu_pkg::*; ();

  // All combinational, BR_NONE values during a bubble
  logic            taken;
  // Conditional branch, trains the predictor
  logic            is_cond;
  // Flush whatever the prediction said
  logic            needs_flush;
  logic            cache_flush;
  // Next PC
  logic [XLEN-1:0] target;
  // Target low bits not zero
  logic            misaligned;

  modport resolver (
    output taken,
    output is_cond,
    output needs_flush,
    output cache_flush,
    output target,
    output misaligned
  );

  modport redirect (
    input taken,
    input is_cond,
    input needs_flush,
    input cache_flush,
    input target,
    input misaligned
  );

endinterface

// ==== hdl/bp_gshare.sv ====
module bp_gshare import bu_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  input  logic [XLEN-1:0] lookup_pc,
  output logic            pred_taken,
  bp_train_if.predictor   train
);

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  // 2-bit saturating counters
  logic [1:0]            bht [2**BHT_BITS];
  // Global history, newest outcome in bit 0
  logic [GHIST_BITS-1:0] ghist;
  logic [BHT_BITS-1:0]   hist_ext;

  logic [BHT_BITS-1:0]   rd_idx;
  logic [BHT_BITS-1:0]   wr_idx;
  logic [1:0]            cnt_cur;
  logic [1:0]            cnt_nxt;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // History zero-extended to index width
  assign hist_ext = {{(BHT_BITS-GHIST_BITS){1'b0}}, ghist};

  // Word-aligned PC bits hashed with history
  assign rd_idx = lookup_pc[BHT_BITS+1:2] ^ hist_ext;

  // MSB of counter is the direction
  assign pred_taken = bht[rd_idx][1];

  //////////////////////////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////////////////////////

  // Same hash, current history
  assign wr_idx = train.pc[BHT_BITS+1:2] ^ hist_ext;

  always_comb begin
    cnt_cur = bht[wr_idx];
    // Saturate at both ends
    if (train.taken) begin
      cnt_nxt = (cnt_cur == 2'b11) ? 2'b11 : cnt_cur + 2'd1;
    end else begin
      cnt_nxt = (cnt_cur == 2'b00) ? 2'b00 : cnt_cur - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      // Weakly not-taken everywhere
      for (int i = 0; i < 2**BHT_BITS; i++) begin
        bht[i] <= 2'b01;
      end
      ghist <= '0;
    end else if (train.update) begin
      bht[wr_idx] <= cnt_nxt;
      ghist       <= {ghist[GHIST_BITS-2:0], train.taken};
    end
  end

  // Training record from redirect stage is always fully defined
  a_train_known: assert property (
    @(posedge clk) disable iff (!rstn)
    !$isunknown(train.update) &&
    (!train.update || !$isunknown({train.pc, train.taken, train.predicted}))
  );

endmodule

// ==== hdl/branch_resolver.sv ====
module branch_resolver import bu_pkg::*; (
  input  logic            id_bubble,
  input  logic [XLEN-1:0] id_pc,
  input  logic [ILEN-1:0] id_instr,
  input  logic [XLEN-1:0] opA,
  input  logic [XLEN-1:0] opB,
  resolve_if.resolver     res
);

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  opc_e            opcode;
  logic [2:0]      func3;
  br_op_e          br_op;

  // Immediates and adders
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] target;

  // Comparator results
  logic            op_eq;
  logic            op_lt;
  logic            op_ltu;
  logic            cond_true;

  assign opcode = opc_e'(id_instr[6:2]);
  assign func3  = id_instr[14:12];

  // J-type, 21-bit signed, bit 0 implied
  assign imm_j = {{(XLEN-20){id_instr[31]}}, id_instr[19:12], id_instr[20],
                  id_instr[30:21], 1'b0};
  // B-type, 13-bit signed, bit 0 implied
  assign imm_b = {{(XLEN-12){id_instr[31]}}, id_instr[7], id_instr[30:25],
                  id_instr[11:8], 1'b0};

  always_comb begin
    br_op = BR_NONE;
    // Bubble keeps BR_NONE
    if (!id_bubble) begin
      case (opcode)
        OPC_JAL:     br_op = BR_JAL;
        OPC_JALR:    if (func3 == F3_JALR) br_op = BR_JALR;
        OPC_BRANCH: begin
          case (func3)
            F3_BEQ:  br_op = BR_BEQ;
            F3_BNE:  br_op = BR_BNE;
            F3_BLT:  br_op = BR_BLT;
            F3_BGE:  br_op = BR_BGE;
            F3_BLTU: br_op = BR_BLTU;
            F3_BGEU: br_op = BR_BGEU;
            // 010 and 011 are reserved
            default: br_op = BR_NONE;
          endcase
        end
        // Plain FENCE and friends fall through as BR_NONE
        OPC_MISCMEM: if (id_instr == FENCE_I) br_op = BR_FENCEI;
        default:     br_op = BR_NONE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Condition
  //////////////////////////////////////////////////////////////////////

  assign op_eq  = (opA == opB);
  assign op_lt  = ($signed(opA) < $signed(opB));
  assign op_ltu = (opA < opB);

  always_comb begin
    case (br_op)
      BR_BEQ:  cond_true = op_eq;
      BR_BNE:  cond_true = !op_eq;
      BR_BLT:  cond_true = op_lt;
      BR_BGE:  cond_true = !op_lt;
      BR_BLTU: cond_true = op_ltu;
      BR_BGEU: cond_true = !op_ltu;
      default: cond_true = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Target
  //////////////////////////////////////////////////////////////////////

  // Always 4, compressed forms not supported
  assign pc_plus4 = id_pc + 32'd4;
  assign jalr_sum = opA + opB;

  always_comb begin
    case (br_op)
      BR_JAL:  target = id_pc + imm_j;
      // LSB cleared per spec
      BR_JALR: target = {jalr_sum[XLEN-1:1], 1'b0};
      default: target = cond_true ? id_pc + imm_b : pc_plus4;
    endcase
  end

  // Outcome
  assign res.taken       = cond_true || (br_op == BR_JAL) || (br_op == BR_JALR);
  assign res.is_cond     = br_op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
  // JAL is redirected in fetch, no flush here
  assign res.needs_flush = (br_op == BR_JALR) || (br_op == BR_FENCEI);
  assign res.cache_flush = (br_op == BR_FENCEI);
  assign res.target      = target;
  assign res.misaligned  = |target[1:0];

endmodule

// ==== hdl/pc_redirect.sv ====
module pc_redirect import bu_pkg::*; (
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                du_stall,
  input  logic                st_flush,
  input  logic                pipe_exc,
  input  logic                pred_taken,
  input  logic                id_bubble,
  input  logic [XLEN-1:0]     id_pc,
  input  logic [EXC_SIZE-1:0] id_exception,
  input  logic                du_we_pc,
  input  logic [XLEN-1:0]     du_dato,
  resolve_if.redirect         res,
  bp_train_if.redirect        train,
  output logic [XLEN-1:0]     nxt_pc,
  output logic                flush,
  output logic                cache_flush,
  output logic                bp_taken,
  output logic                bp_update,
  output logic [EXC_SIZE-1:0] exception
);

  logic            pipeflush;
  logic            chk_misaligned;

  // Debug PC write tracking
  logic            du_we_pc_dly;
  logic            du_wrote_pc;
  logic [XLEN-1:0] du_nxt_pc;

  // Training record
  logic            upd_r;
  logic            taken_r;
  logic            pred_r;
  logic [XLEN-1:0] pc_r;

  //////////////////////////////////////////////////////////////////////
  // Combine prediction and resolution
  //////////////////////////////////////////////////////////////////////

  // Mispredicted direction or unconditional flush
  assign pipeflush = res.needs_flush || (res.is_cond && (res.taken != pred_taken));

  // Branches and JALR only; JALR is the flush without cache flush
  assign chk_misaligned = !id_bubble &&
                          (res.is_cond || (res.needs_flush && !res.cache_flush));

  //////////////////////////////////////////////////////////////////////
  // Debug unit PC write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_we_pc_dly <= 1'b0;
      du_wrote_pc  <= 1'b0;
    end else begin
      du_we_pc_dly <= du_we_pc;
      // Sticky until debugger releases the stall
      du_wrote_pc  <= du_we_pc || (du_wrote_pc && du_stall);
    end
  end

  always_ff @(posedge clk) begin
    if (du_we_pc) du_nxt_pc <= du_dato;
  end

  //////////////////////////////////////////////////////////////////////
  // Registered redirect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      // Fetch starts on a flush to PC_INIT
      flush       <= 1'b1;
      cache_flush <= 1'b0;
      nxt_pc      <= PC_INIT;
      upd_r       <= 1'b0;
      taken_r     <= 1'b0;
    end else if (du_wrote_pc) begin
      // Debugger owns the PC
      flush       <= du_we_pc_dly;
      cache_flush <= 1'b0;
      nxt_pc      <= du_nxt_pc;
      upd_r       <= 1'b0;
      taken_r     <= 1'b0;
    end else begin
      flush       <= pipeflush && !du_stall;
      cache_flush <= res.cache_flush;
      nxt_pc      <= res.target;
      upd_r       <= res.is_cond;
      taken_r     <= res.taken;
    end
  end

  // Branch PC and lookup result, qualified by upd_r
  always_ff @(posedge clk) begin
    pc_r   <= id_pc;
    pred_r <= pred_taken;
  end

  assign train.update    = upd_r;
  assign train.pc        = pc_r;
  assign train.taken     = taken_r;
  assign train.predicted = pred_r;

  assign bp_update = train.update;
  assign bp_taken  = train.taken;

  //////////////////////////////////////////////////////////////////////
  // Exceptions
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      exception <= '0;
    end else if (!ex_stall) begin
      if (flush || st_flush || pipe_exc) begin
        exception <= '0;
      end else if (!du_stall) begin
        exception <= id_exception;
        exception[CAUSE_MISALIGNED_INSTR] <= id_exception[CAUSE_MISALIGNED_INSTR] ||
                                             (chk_misaligned && res.misaligned);
      end
    end
  end

  // Debug PC write is one pulse, issued inside a debug stall
  a_du_we_pc_pulse: assert property (
    @(posedge clk) disable iff (!rstn)
    du_we_pc |-> du_stall ##1 !du_we_pc
  );

endmodule

// ==== hdl/branch_top.sv ====
module branch_top import bu_pkg::*; (
  input  logic                clk,
  input  logic                rstn,

  // Pipeline control
  input  logic                ex_stall,
  input  logic                du_stall,
  input  logic                st_flush,
  input  logic                pipe_exc,

  // ID stage
  input  logic                id_bubble,
  input  logic [XLEN-1:0]     id_pc,
  input  logic [ILEN-1:0]     id_instr,
  input  logic [XLEN-1:0]     opA,
  input  logic [XLEN-1:0]     opB,
  input  logic [EXC_SIZE-1:0] id_exception,

  // Debug unit
  input  logic                du_we_pc,
  input  logic [XLEN-1:0]     du_dato,

  // Results
  output logic                pred_taken,
  output logic [XLEN-1:0]     nxt_pc,
  output logic                flush,
  output logic                cache_flush,
  output logic                bp_taken,
  output logic                bp_update,
  output logic [EXC_SIZE-1:0] exception
);

  // Internal buses
  resolve_if  res_bus ();
  bp_train_if train_bus ();

  // Direction lookup for the ID PC
  bp_gshare u_gshare (
    .clk        (clk),
    .rstn       (rstn),
    .lookup_pc  (id_pc),
    .pred_taken (pred_taken),
    .train      (train_bus.predictor)
  );

  branch_resolver u_resolver (
    .id_bubble (id_bubble),
    .id_pc     (id_pc),
    .id_instr  (id_instr),
    .opA       (opA),
    .opB       (opB),
    .res       (res_bus.resolver)
  );

  // Registers every output except pred_taken
  pc_redirect u_redirect (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .du_stall     (du_stall),
    .st_flush     (st_flush),
    .pipe_exc     (pipe_exc),
    .pred_taken   (pred_taken),
    .id_bubble    (id_bubble),
    .id_pc        (id_pc),
    .id_exception (id_exception),
    .du_we_pc     (du_we_pc),
    .du_dato      (du_dato),
    .res          (res_bus.redirect),
    .train        (train_bus.redirect),
    .nxt_pc       (nxt_pc),
    .flush        (flush),
    .cache_flush  (cache_flush),
    .bp_taken     (bp_taken),
    .bp_update    (bp_update),
    .exception    (exception)
  );

endmodule

// ==== tests/tb_checker.sv ====
module tb_checker import bu_pkg::*; (
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                du_stall,
  input  logic                st_flush,
  input  logic                pipe_exc,
  input  logic                id_bubble,
  input  logic [XLEN-1:0]     id_pc,
  input  logic [ILEN-1:0]     id_instr,
  input  logic [XLEN-1:0]     opA,
  input  logic [XLEN-1:0]     opB,
  input  logic [EXC_SIZE-1:0] id_exception,
  input  logic                du_we_pc,
  input  logic [XLEN-1:0]     du_dato,
  input  logic                pred_taken,
  input  logic [XLEN-1:0]     nxt_pc,
  input  logic                flush,
  input  logic                cache_flush,
  input  logic                bp_taken,
  input  logic                bp_update,
  input  logic [EXC_SIZE-1:0] exception,
  output int                  errors,
  output int                  checks
);

  // Reference gshare
  logic [1:0]            bht_m [2**BHT_BITS];
  logic [GHIST_BITS-1:0] ghist_m;
  logic [BHT_BITS-1:0]   widx;

  // Expected registered outputs
  logic                e_flush;
  logic                e_cflush;
  logic                e_upd;
  logic                e_taken;
  logic [XLEN-1:0]     e_pc;
  logic [EXC_SIZE-1:0] e_exc;
  // PC of the pending training record
  logic [XLEN-1:0]     rec_pc;

  // Debug write tracking
  logic            we_dly;
  logic            wrote;
  logic [XLEN-1:0] du_pc;

  // Resolution of the ID instruction this cycle
  logic            r_taken;
  logic            r_cond;
  logic            r_jalr;
  logic            r_cf;
  logic [XLEN-1:0] r_tgt;
  logic            p;

  logic model_ok = 1'b0;
  int   err_cnt  = 0;
  int   chk_cnt  = 0;

  assign errors = err_cnt;
  assign checks = chk_cnt;

  // Counter MSB at PC[7:2] xor history
  function automatic logic lookup(input logic [XLEN-1:0] pc);
    logic [BHT_BITS-1:0] idx;
    idx    = pc[7:2] ^ {2'b00, ghist_m};
    lookup = bht_m[idx][1];
  endfunction

  // RV32I control-transfer rules, from the ID inputs
  task automatic resolve_id();
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    logic [2:0]      f3;
    logic            hit;
    f3      = id_instr[14:12];
    imm_j   = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20], id_instr[30:21], 1'b0};
    imm_b   = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
    hit     = 1'b0;
    r_taken = 1'b0;
    r_cond  = 1'b0;
    r_jalr  = 1'b0;
    r_cf    = 1'b0;
    r_tgt   = id_pc + 32'd4;
    if (!id_bubble) begin
      case (id_instr[6:0])
        7'b1101111: begin
          r_taken = 1'b1;
          r_tgt   = id_pc + imm_j;
        end
        7'b1100111: begin
          if (f3 == 3'b000) begin
            r_taken = 1'b1;
            r_jalr  = 1'b1;
            r_tgt   = (opA + opB) & ~32'd1;
          end
        end
        7'b1100011: begin
          // 010 and 011 are no branch
          r_cond = (f3 != 3'b010) && (f3 != 3'b011);
          case (f3)
            3'b000:  hit = (opA == opB);
            3'b001:  hit = (opA != opB);
            3'b100:  hit = ($signed(opA) < $signed(opB));
            3'b101:  hit = ($signed(opA) >= $signed(opB));
            3'b110:  hit = (opA < opB);
            3'b111:  hit = (opA >= opB);
            default: hit = 1'b0;
          endcase
          r_taken = hit;
          if (hit) r_tgt = id_pc + imm_b;
        end
        default: r_cf = (id_instr == 32'h0000_100f);
      endcase
    end
  endtask

  task automatic compare(input string name, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Model step, inputs are stable at the edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 2**BHT_BITS; i++) begin
        bht_m[i] = 2'b01;
      end
      ghist_m  = '0;
      e_flush  = 1'b1;
      e_cflush = 1'b0;
      e_pc     = PC_INIT;
      e_upd    = 1'b0;
      e_taken  = 1'b0;
      e_exc    = '0;
      we_dly   = 1'b0;
      wrote    = 1'b0;
    end else begin
      resolve_id();
      // Direction as seen before this edge
      p = lookup(id_pc);
      // Cleared by last cycle's flush
      if (!ex_stall) begin
        if (e_flush || st_flush || pipe_exc) begin
          e_exc = '0;
        end else if (!du_stall) begin
          e_exc = id_exception;
          if (!id_bubble && (r_cond || r_jalr) && (r_tgt[1:0] != 2'b00))
            e_exc[CAUSE_MISALIGNED_INSTR] = 1'b1;
        end
      end
      // Previous edge's record trains now
      if (e_upd) begin
        widx = rec_pc[7:2] ^ {2'b00, ghist_m};
        if (e_taken && bht_m[widx] != 2'b11) bht_m[widx] = bht_m[widx] + 2'd1;
        if (!e_taken && bht_m[widx] != 2'b00) bht_m[widx] = bht_m[widx] - 2'd1;
        ghist_m = {ghist_m[GHIST_BITS-2:0], e_taken};
      end
      if (wrote) begin
        // Debugger PC until the stall drops
        e_flush  = we_dly;
        e_cflush = 1'b0;
        e_pc     = du_pc;
        e_upd    = 1'b0;
        e_taken  = 1'b0;
      end else begin
        e_flush  = (r_jalr || r_cf || (r_cond && (r_taken != p))) && !du_stall;
        e_cflush = r_cf;
        e_pc     = r_tgt;
        e_upd    = r_cond;
        e_taken  = r_taken;
      end
      rec_pc = id_pc;
      wrote  = du_we_pc || (wrote && du_stall);
      we_dly = du_we_pc;
      if (du_we_pc) du_pc = du_dato;
    end
    model_ok = 1'b1;
  end

  // Outputs settled mid-cycle
  always @(negedge clk) begin
    if (model_ok) begin
      compare("nxt_pc", e_pc, nxt_pc);
      compare("flush", {31'b0, e_flush}, {31'b0, flush});
      compare("cache_flush", {31'b0, e_cflush}, {31'b0, cache_flush});
      compare("bp_update", {31'b0, e_upd}, {31'b0, bp_update});
      compare("bp_taken", {31'b0, e_taken}, {31'b0, bp_taken});
      compare("exception", {{(32-EXC_SIZE){1'b0}}, e_exc},
              {{(32-EXC_SIZE){1'b0}}, exception});
      compare("pred_taken", {31'b0, lookup(id_pc)}, {31'b0, pred_taken});
    end
  end

endmodule

// ==== tests/tb_top.sv ====
module tb_top import bu_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // Run length and timing
  //////////////////////////////////////////////////////////////////////

  localparam int PERIOD     = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_CYCLES   = 3000;
  // Inputs change this long after the rising edge
  localparam int DRIVE_DLY  = 10;
  // Whole run plus slack for reset and drain
  localparam int WATCHDOG_T = (RST_CYCLES + N_CYCLES + 50) * PERIOD;

  logic                clk;
  logic                rstn;
  logic                ex_stall;
  logic                du_stall;
  logic                st_flush;
  logic                pipe_exc;
  logic                id_bubble;
  logic [XLEN-1:0]     id_pc;
  logic [ILEN-1:0]     id_instr;
  logic [XLEN-1:0]     opA;
  logic [XLEN-1:0]     opB;
  logic [EXC_SIZE-1:0] id_exception;
  logic                du_we_pc;
  logic [XLEN-1:0]     du_dato;
  logic                pred_taken;
  logic [XLEN-1:0]     nxt_pc;
  logic                flush;
  logic                cache_flush;
  logic                bp_taken;
  logic                bp_update;
  logic [EXC_SIZE-1:0] exception;

  // Random state and debug sequence length
  int seed;
  int dbg_left;
  // Totals from the checker
  int errors;
  int checks;

  initial clk = 1'b0;
  always #(PERIOD/2) clk = ~clk;

  branch_top DUT (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .du_stall     (du_stall),
    .st_flush     (st_flush),
    .pipe_exc     (pipe_exc),
    .id_bubble    (id_bubble),
    .id_pc        (id_pc),
    .id_instr     (id_instr),
    .opA          (opA),
    .opB          (opB),
    .id_exception (id_exception),
    .du_we_pc     (du_we_pc),
    .du_dato      (du_dato),
    .pred_taken   (pred_taken),
    .nxt_pc       (nxt_pc),
    .flush        (flush),
    .cache_flush  (cache_flush),
    .bp_taken     (bp_taken),
    .bp_update    (bp_update),
    .exception    (exception)
  );

  // Scoreboard sees every DUT port by name
  tb_checker u_checker (.*);

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  // Eight control transfers, FENCE.I, FENCE, ALU, raw words
  function automatic logic [ILEN-1:0] make_instr(input int kind, input logic [31:0] r);
    case (kind)
      0:       make_instr = {r[31:7], 7'b1101111};
      1:       make_instr = {r[31:15], 3'b000, r[11:7], 7'b1100111};
      2:       make_instr = {r[31:15], 3'b000, r[11:7], 7'b1100011};
      3:       make_instr = {r[31:15], 3'b001, r[11:7], 7'b1100011};
      4:       make_instr = {r[31:15], 3'b100, r[11:7], 7'b1100011};
      5:       make_instr = {r[31:15], 3'b101, r[11:7], 7'b1100011};
      6:       make_instr = {r[31:15], 3'b110, r[11:7], 7'b1100011};
      7:       make_instr = {r[31:15], 3'b111, r[11:7], 7'b1100011};
      8:       make_instr = 32'h0000_100f;
      9:       make_instr = {r[31:15], 3'b000, r[11:7], 7'b0001111};
      10:      make_instr = {r[31:7], r[0] ? 7'b0010011 : 7'b0110011};
      // Any 32-bit form, may hit reserved branch func3
      default: make_instr = {r[31:2], 2'b11};
    endcase
  endfunction

  // Values around zero and the sign boundary
  function automatic logic [XLEN-1:0] edge_value(input logic [2:0] sel);
    case (sel)
      3'd0:    edge_value = 32'h0000_0000;
      3'd1:    edge_value = 32'h0000_0001;
      3'd2:    edge_value = 32'h7fff_ffff;
      3'd3:    edge_value = 32'h8000_0000;
      3'd4:    edge_value = 32'h8000_0001;
      default: edge_value = 32'hffff_ffff;
    endcase
  endfunction

  task automatic idle_inputs();
    ex_stall     = 1'b0;
    du_stall     = 1'b0;
    st_flush     = 1'b0;
    pipe_exc     = 1'b0;
    id_bubble    = 1'b1;
    id_pc        = PC_INIT;
    // NOP
    id_instr     = 32'h0000_0013;
    opA          = '0;
    opB          = '0;
    id_exception = '0;
    du_we_pc     = 1'b0;
    du_dato      = '0;
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    logic [31:0] t;
    int          kind;
    r         = next_random();
    t         = next_random();
    kind      = int'(r % 12);
    id_instr  = make_instr(kind, next_random());
    id_bubble = (r[7:4] == 4'd0);
    // Small PC pool so counters see repeat visits
    id_pc     = PC_INIT | (next_random() & 32'h0000_00fc);
    if (r[11:8] == 4'd0) id_pc[1:0] = r[13:12];
    case (r[15:14])
      2'd0: begin
        opA = next_random();
        opB = opA;
      end
      2'd1: begin
        opA = edge_value(r[18:16]);
        opB = edge_value(r[21:19]);
      end
      default: begin
        opA = next_random();
        opB = next_random();
      end
    endcase
    ex_stall     = (t[3:0] == 4'd0);
    st_flush     = (t[8:4] == 5'd0);
    pipe_exc     = (t[13:9] == 5'd0);
    id_exception = (t[17:14] == 4'd0) ? t[31:16] : '0;
    // Debug PC write, then a few cycles still stalled
    du_we_pc = 1'b0;
    if (dbg_left > 0) begin
      du_stall = 1'b1;
      dbg_left--;
    end else if (t[23:18] == 6'd0) begin
      du_stall = 1'b1;
      du_we_pc = 1'b1;
      du_dato  = next_random();
      dbg_left = 2 + int'(t[26:24]);
    end else begin
      du_stall = (t[30:27] == 4'd0) && t[31];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed     = 6;
    dbg_left = 0;
    rstn     = 1'b0;
    idle_inputs();
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rstn = 1'b1;
    for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
      @(posedge clk);
      #DRIVE_DLY;
      drive_cycle();
    end
    @(posedge clk);
    #DRIVE_DLY;
    idle_inputs();
    // Drain, past the last negedge compare
    repeat (3) @(posedge clk);
    #(PERIOD*3/4);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_T);
    $display("Timeout: run did not finish within %0d time units", WATCHDOG_T);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/bu_pkg.sv
hdl/bp_train_if.sv
hdl/resolve_if.sv
hdl/bp_gshare.sv
hdl/branch_resolver.sv
hdl/pc_redirect.sv
hdl/branch_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the branch resolution testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
